// ==== mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// timer window, everything else goes out on the AXI port
`define CLINT_BASE (32'h0200_0000)
`define CLINT_SIZE (32'h0001_0000)

// AXI response codes
`define RESP_OKAY   (2'd0)
`define RESP_SLVERR (2'd2)

`endif

// ==== bus_pkg.sv ====
`default_nettype none

`include "mem_params.svh"

package bus_pkg;

    // byte address
    typedef logic [`ADDR_W-1:0] addr_t;

    // data word
    typedef logic [`DATA_W-1:0] data_t;

    // one enable per byte lane
    typedef logic [`STRB_W-1:0] strb_t;

    typedef logic [1:0] resp_t;

    // machine timer
    typedef logic [63:0] mtime_t;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE, WR_ADDR_DATA, WR_RESP, RD_ADDR,
        RD_DATA, CLINT_RD, CLINT_WAIT, DONE
    } bridge_state_t;

    // owner of the shared access bus
    typedef enum logic {FETCH, LSU} requester_t;

endpackage

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           fetch_req,
    input  wire bus_pkg::addr_t fetch_addr,
    output bus_pkg::data_t      fetch_rdata,
    output bus_pkg::resp_t      fetch_resp,
    output logic                fetch_done,
    input  wire logic           lsu_req,
    input  wire logic           lsu_write,
    input  wire bus_pkg::addr_t lsu_addr,
    input  wire bus_pkg::data_t lsu_wdata,
    input  wire bus_pkg::strb_t lsu_strb,
    output bus_pkg::data_t      lsu_rdata,
    output bus_pkg::resp_t      lsu_resp,
    output logic                lsu_done,
    output logic                acc_req,
    output logic                acc_write,
    output bus_pkg::addr_t      acc_addr,
    output bus_pkg::data_t      acc_wdata,
    output bus_pkg::strb_t      acc_strb,
    input  wire logic           acc_done,
    input  wire bus_pkg::data_t acc_rdata,
    input  wire bus_pkg::resp_t acc_resp
);
    import ctrl_pkg::*;

    logic busy;
    requester_t owner;
    requester_t sel;

    // load/store wins when both ask in the same idle cycle
    assign sel = busy ? owner : (lsu_req ? LSU : FETCH);

    assign acc_req   = (sel == LSU) ? lsu_req : fetch_req;
    assign acc_write = (sel == LSU) ? lsu_write : 1'b0;
    assign acc_addr  = (sel == LSU) ? lsu_addr : fetch_addr;
    assign acc_wdata = lsu_wdata;
    assign acc_strb  = (sel == LSU) ? lsu_strb : '0;

    // completion goes to the owner only
    assign fetch_done  = busy & acc_done & (owner == FETCH);
    assign lsu_done    = busy & acc_done & (owner == LSU);
    assign fetch_rdata = acc_rdata;
    assign fetch_resp  = acc_resp;
    assign lsu_rdata   = acc_rdata;
    assign lsu_resp    = acc_resp;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= FETCH;
        end else if (!busy) begin
            if (acc_req) begin
                busy  <= 1'b1;
                owner <= sel;
            end
        end else if (acc_done) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module clint_timer (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           clint_rd,
    input  wire bus_pkg::addr_t clint_addr,
    output bus_pkg::data_t      clint_rdata
);
    import bus_pkg::*;

    mtime_t mtime;
    addr_t offset;

    assign offset = clint_addr - `CLINT_BASE;

    // free running, no compare or write path
    always_ff @(posedge clock) begin
        if (reset) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // answer lands one cycle after clint_rd
    always_ff @(posedge clock) begin
        if (clint_rd) begin
            case (offset)
                32'd8: begin
                    clint_rdata <= mtime[`DATA_W-1:0];
                end
                32'd12: begin
                    clint_rdata <= mtime[63:`DATA_W];
                end
                default: begin
                    clint_rdata <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== axi_lite_bridge_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module axi_lite_bridge_fsm (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           acc_req,
    input  wire logic           acc_write,
    input  wire bus_pkg::addr_t acc_addr,
    input  wire bus_pkg::data_t acc_wdata,
    input  wire bus_pkg::strb_t acc_strb,
    output logic                acc_done,
    output bus_pkg::data_t      acc_rdata,
    output bus_pkg::resp_t      acc_resp,
    output logic                clint_rd,
    output bus_pkg::addr_t      clint_addr,
    input  wire bus_pkg::data_t clint_rdata,
    output logic                awvalid,
    input  wire logic           awready,
    output bus_pkg::addr_t      awaddr,
    output logic                wvalid,
    input  wire logic           wready,
    output bus_pkg::data_t      wdata,
    output bus_pkg::strb_t      wstrb,
    input  wire logic           bvalid,
    output logic                bready,
    input  wire bus_pkg::resp_t bresp,
    output logic                arvalid,
    input  wire logic           arready,
    output bus_pkg::addr_t      araddr,
    input  wire logic           rvalid,
    output logic                rready,
    input  wire bus_pkg::data_t rdata,
    input  wire bus_pkg::resp_t rresp
);
    import bus_pkg::*;
    import ctrl_pkg::*;

    bridge_state_t state;
    addr_t addr_q;
    data_t wdata_q;
    strb_t strb_q;
    data_t rdata_q;
    resp_t resp_q;
    logic in_clint;
    logic grant;
    logic aw_fire;
    logic w_fire;
    logic aw_left;
    logic w_left;
    logic b_fire;
    logic ar_fire;
    logic r_fire;

    // only checked while idle
    assign in_clint = (acc_addr >= `CLINT_BASE) && (acc_addr < (`CLINT_BASE + `CLINT_SIZE));
    assign grant    = (state == IDLE) && acc_req;

    assign arvalid  = (state == RD_ADDR);
    assign bready   = (state == WR_RESP);
    assign rready   = (state == RD_DATA);
    assign clint_rd = (state == CLINT_RD);
    assign acc_done = (state == DONE);

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign aw_left = awvalid & ~awready;
    assign w_left  = wvalid & ~wready;
    assign b_fire  = bvalid & bready;
    assign ar_fire = arvalid & arready;
    assign r_fire  = rvalid & rready;

    assign awaddr     = addr_q;
    assign araddr     = addr_q;
    assign clint_addr = addr_q;
    assign wdata      = wdata_q;
    assign wstrb      = strb_q;
    assign acc_rdata  = rdata_q;
    assign acc_resp   = resp_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (acc_req) begin
                        if (in_clint) begin
                            // timer is read only, writes end at once
                            state <= acc_write ? DONE : CLINT_RD;
                        end else if (acc_write) begin
                            state   <= WR_ADDR_DATA;
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end else begin
                            state <= RD_ADDR;
                        end
                    end
                end
                WR_ADDR_DATA: begin
                    // aw and w may complete in either order
                    if (aw_fire) begin
                        awvalid <= 1'b0;
                    end
                    if (w_fire) begin
                        wvalid <= 1'b0;
                    end
                    if (!aw_left && !w_left) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        state <= DONE;
                    end
                end
                RD_ADDR: begin
                    if (ar_fire) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_fire) begin
                        state <= DONE;
                    end
                end
                CLINT_RD: begin
                    state <= CLINT_WAIT;
                end
                CLINT_WAIT: begin
                    state <= DONE;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // access payload and captured reply
    always_ff @(posedge clock) begin
        if (grant) begin
            addr_q  <= acc_addr;
            wdata_q <= acc_wdata;
            strb_q  <= acc_strb;
        end
        if (grant && in_clint && acc_write) begin
            rdata_q <= '0;
            resp_q  <= `RESP_SLVERR;
        end
        if (b_fire) begin
            rdata_q <= '0;
            resp_q  <= bresp;
        end
        if (r_fire) begin
            rdata_q <= rdata;
            resp_q  <= rresp;
        end
        if (state == CLINT_WAIT) begin
            rdata_q <= clint_rdata;
            resp_q  <= `RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== mem_access_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_top (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           fetch_req,
    input  wire bus_pkg::addr_t fetch_addr,
    output bus_pkg::data_t      fetch_rdata,
    output bus_pkg::resp_t      fetch_resp,
    output logic                fetch_done,
    input  wire logic           lsu_req,
    input  wire logic           lsu_write,
    input  wire bus_pkg::addr_t lsu_addr,
    input  wire bus_pkg::data_t lsu_wdata,
    input  wire bus_pkg::strb_t lsu_strb,
    output bus_pkg::data_t      lsu_rdata,
    output bus_pkg::resp_t      lsu_resp,
    output logic                lsu_done,
    output logic                awvalid,
    input  wire logic           awready,
    output bus_pkg::addr_t      awaddr,
    output logic                wvalid,
    input  wire logic           wready,
    output bus_pkg::data_t      wdata,
    output bus_pkg::strb_t      wstrb,
    input  wire logic           bvalid,
    output logic                bready,
    input  wire bus_pkg::resp_t bresp,
    output logic                arvalid,
    input  wire logic           arready,
    output bus_pkg::addr_t      araddr,
    input  wire logic           rvalid,
    output logic                rready,
    input  wire bus_pkg::data_t rdata,
    input  wire bus_pkg::resp_t rresp
);
    import bus_pkg::*;

    logic acc_req;
    logic acc_write;
    addr_t acc_addr;
    data_t acc_wdata;
    strb_t acc_strb;
    logic acc_done;
    data_t acc_rdata;
    resp_t acc_resp;
    logic clint_rd;
    addr_t clint_addr;
    data_t clint_rdata;

    mem_arbiter i_arbiter (
        .clock       (clock),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_rdata (fetch_rdata),
        .fetch_resp  (fetch_resp),
        .fetch_done  (fetch_done),
        .lsu_req     (lsu_req),
        .lsu_write   (lsu_write),
        .lsu_addr    (lsu_addr),
        .lsu_wdata   (lsu_wdata),
        .lsu_strb    (lsu_strb),
        .lsu_rdata   (lsu_rdata),
        .lsu_resp    (lsu_resp),
        .lsu_done    (lsu_done),
        .acc_req     (acc_req),
        .acc_write   (acc_write),
        .acc_addr    (acc_addr),
        .acc_wdata   (acc_wdata),
        .acc_strb    (acc_strb),
        .acc_done    (acc_done),
        .acc_rdata   (acc_rdata),
        .acc_resp    (acc_resp)
    );

    axi_lite_bridge_fsm i_bridge (
        .clock       (clock),
        .reset       (reset),
        .acc_req     (acc_req),
        .acc_write   (acc_write),
        .acc_addr    (acc_addr),
        .acc_wdata   (acc_wdata),
        .acc_strb    (acc_strb),
        .acc_done    (acc_done),
        .acc_rdata   (acc_rdata),
        .acc_resp    (acc_resp),
        .clint_rd    (clint_rd),
        .clint_addr  (clint_addr),
        .clint_rdata (clint_rdata),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp)
    );

    clint_timer i_clint (
        .clock       (clock),
        .reset       (reset),
        .clint_rd    (clint_rd),
        .clint_addr  (clint_addr),
        .clint_rdata (clint_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_access;
    import bus_pkg::*;

    localparam int CLK_NS = 4;
    localparam int RESET_CYCLES = 5;
    localparam int N_RANDOM = 150;
    // directed part plus random part, a race counts twice
    localparam int MAX_ACCESSES = 20 + 2 * N_RANDOM;
    localparam int WATCHDOG_NS = (RESET_CYCLES + 20 * MAX_ACCESSES) * CLK_NS;
    localparam int unsigned SEED = 32'h5a98_edd4;

    logic clock = 1'b0;
    logic reset;
    logic fetch_req;
    addr_t fetch_addr;
    data_t fetch_rdata;
    resp_t fetch_resp;
    logic fetch_done;
    logic lsu_req;
    logic lsu_write;
    addr_t lsu_addr;
    data_t lsu_wdata;
    strb_t lsu_strb;
    data_t lsu_rdata;
    resp_t lsu_resp;
    logic lsu_done;
    logic awvalid;
    logic awready;
    addr_t awaddr;
    logic wvalid;
    logic wready;
    data_t wdata;
    strb_t wstrb;
    logic bvalid;
    logic bready;
    resp_t bresp;
    logic arvalid;
    logic arready;
    addr_t araddr;
    logic rvalid;
    logic rready;
    data_t rdata;
    resp_t rresp;

    data_t slave_mem [addr_t];
    data_t model_mem [addr_t];
    // per request channel: 0 aw, 1 w, 2 ar
    int unsigned ready_wait [3];
    bit pending [3];
    logic [63:0] held [3];
    int errors = 0;
    int aw_count = 0;
    int w_count = 0;
    int ar_count = 0;
    int ext_txns = 0;
    int unsigned cycles;
    data_t last_lo = '0;

    mem_access_top i_mem_access_top (.*);

    always #(CLK_NS / 2) clock = ~clock;

    // same count as mtime
    always @(posedge clock) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // unwritten words, every address bit matters
    function automatic data_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic data_t slave_word(input addr_t a);
        return slave_mem.exists(a) ? slave_mem[a] : fill_word(a);
    endfunction

    function automatic data_t model_word(input addr_t a);
        return model_mem.exists(a) ? model_mem[a] : fill_word(a);
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t st);
        data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) begin
                r[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic addr_t pick_ext();
        return 32'h8000_0000 | (($urandom % 8) << 2);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // ready for one request channel, a waiting valid must keep its payload
    task automatic request_ready(input int ch, input logic valid, input logic [63:0] payload,
                                 input string name, output logic ready);
        ready = 1'b0;
        if (pending[ch]) begin
            check_value({name, " valid held"}, 64'd1, 64'(valid));
            if (valid) begin
                check_value({name, " payload held"}, held[ch], payload);
            end
        end
        if (valid && !pending[ch]) begin
            pending[ch] = 1'b1;
            held[ch] = payload;
        end
        if (!valid) begin
            pending[ch] = 1'b0;
        end else if (ready_wait[ch] == 0) begin
            ready = 1'b1;
            pending[ch] = 1'b0;
            ready_wait[ch] = $urandom % 4;
        end else begin
            ready_wait[ch] = ready_wait[ch] - 1;
        end
    endtask

    // AXI4-lite slave, all decisions on the falling edge
    initial begin
        bit b_fire;
        bit r_fire;
        bit aw_taken;
        bit w_taken;
        bit ar_taken;
        int unsigned b_wait;
        int unsigned r_wait;
        addr_t wr_addr;
        data_t wr_data;
        strb_t wr_strb;
        addr_t rd_addr;
        awready = 1'b0;
        wready = 1'b0;
        arready = 1'b0;
        bvalid = 1'b0;
        bresp = `RESP_OKAY;
        rvalid = 1'b0;
        rdata = '0;
        rresp = `RESP_OKAY;
        b_fire = 1'b0;
        r_fire = 1'b0;
        aw_taken = 1'b0;
        w_taken = 1'b0;
        ar_taken = 1'b0;
        b_wait = 0;
        r_wait = 0;
        for (int ch = 0; ch < 3; ch++) begin
            ready_wait[ch] = 0;
            pending[ch] = 1'b0;
        end
        forever begin
            @(negedge clock);
            // responses first so they only follow finished handshakes
            if (b_fire) begin
                bvalid = 1'b0;
            end else if (!bvalid && aw_taken && w_taken) begin
                if (b_wait == 0) begin
                    slave_mem[wr_addr] = merge_bytes(slave_word(wr_addr), wr_data, wr_strb);
                    bvalid = 1'b1;
                    bresp = `RESP_OKAY;
                    aw_taken = 1'b0;
                    w_taken = 1'b0;
                    ext_txns++;
                    b_wait = $urandom % 4;
                end else begin
                    b_wait = b_wait - 1;
                end
            end
            b_fire = bvalid && bready;
            if (r_fire) begin
                rvalid = 1'b0;
            end else if (!rvalid && ar_taken) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata = slave_word(rd_addr);
                    rresp = `RESP_OKAY;
                    ar_taken = 1'b0;
                    ext_txns++;
                    r_wait = $urandom % 4;
                end else begin
                    r_wait = r_wait - 1;
                end
            end
            r_fire = rvalid && rready;
            request_ready(0, awvalid, 64'(awaddr), "awaddr", awready);
            if (awready) begin
                wr_addr = awaddr;
                aw_taken = 1'b1;
                aw_count++;
            end
            request_ready(1, wvalid, 64'({wstrb, wdata}), "wdata", wready);
            if (wready) begin
                wr_data = wdata;
                wr_strb = wstrb;
                w_taken = 1'b1;
                w_count++;
            end
            request_ready(2, arvalid, 64'(araddr), "araddr", arready);
            if (arready) begin
                rd_addr = araddr;
                ar_taken = 1'b1;
                ar_count++;
            end
        end
    end

    // one access, waits for its done and counts the cycles
    task automatic run_access(input bit from_lsu, input bit wr, input addr_t addr,
                              input data_t wd, input strb_t st,
                              output data_t rd, output resp_t rs, output int lat);
        bit got;
        @(negedge clock);
        if (from_lsu) begin
            lsu_req = 1'b1;
            lsu_write = wr;
            lsu_addr = addr;
            lsu_wdata = wd;
            lsu_strb = st;
        end else begin
            fetch_req = 1'b1;
            fetch_addr = addr;
        end
        lat = 0;
        got = 1'b0;
        while (!got) begin
            @(negedge clock);
            lat++;
            if (from_lsu) begin
                check_value("fetch_done", 64'd0, 64'(fetch_done));
                got = lsu_done;
                rd = lsu_rdata;
                rs = lsu_resp;
            end else begin
                check_value("lsu_done", 64'd0, 64'(lsu_done));
                got = fetch_done;
                rd = fetch_rdata;
                rs = fetch_resp;
            end
        end
        lsu_req = 1'b0;
        fetch_req = 1'b0;
    endtask

    task automatic ext_write(input addr_t addr, input data_t wd, input strb_t st);
        data_t rd;
        resp_t rs;
        int lat;
        int aw0;
        int w0;
        int ar0;
        int tx0;
        aw0 = aw_count;
        w0 = w_count;
        ar0 = ar_count;
        tx0 = ext_txns;
        run_access(1'b1, 1'b1, addr, wd, st, rd, rs, lat);
        check_value("lsu_resp", 64'(`RESP_OKAY), 64'(rs));
        check_value("aw handshakes", 64'(aw0 + 1), 64'(aw_count));
        check_value("w handshakes", 64'(w0 + 1), 64'(w_count));
        check_value("ar handshakes", 64'(ar0), 64'(ar_count));
        check_value("external transactions", 64'(tx0 + 1), 64'(ext_txns));
        model_mem[addr] = merge_bytes(model_word(addr), wd, st);
    endtask

    task automatic ext_read(input bit from_lsu, input addr_t addr);
        data_t rd;
        resp_t rs;
        int lat;
        int ar0;
        int aw0;
        int tx0;
        string who;
        if (from_lsu) begin
            who = "lsu";
        end else begin
            who = "fetch";
        end
        ar0 = ar_count;
        aw0 = aw_count;
        tx0 = ext_txns;
        run_access(from_lsu, 1'b0, addr, '0, '0, rd, rs, lat);
        check_value({who, "_rdata"}, 64'(model_word(addr)), 64'(rd));
        check_value({who, "_resp"}, 64'(`RESP_OKAY), 64'(rs));
        check_value("ar handshakes", 64'(ar0 + 1), 64'(ar_count));
        check_value("aw handshakes", 64'(aw0), 64'(aw_count));
        check_value("external transactions", 64'(tx0 + 1), 64'(ext_txns));
    endtask

    task automatic clint_read(input bit from_lsu, input addr_t offset);
        data_t rd;
        resp_t rs;
        int lat;
        int ar0;
        int tx0;
        ar0 = ar_count;
        tx0 = ext_txns;
        run_access(from_lsu, 1'b0, `CLINT_BASE + offset, '0, '0, rd, rs, lat);
        check_value("clint read resp", 64'(`RESP_OKAY), 64'(rs));
        check_value("clint read latency", 64'd3, 64'(lat));
        check_value("ar handshakes", 64'(ar0), 64'(ar_count));
        check_value("external transactions", 64'(tx0), 64'(ext_txns));
        if (offset == 32'd8) begin
            check_value("mtime low increases", 64'd1, 64'(rd > last_lo));
            check_value("mtime low within cycles", 64'd1, 64'(rd <= cycles));
            last_lo = rd;
        end else begin
            // high word stays zero in a run this short
            check_value("clint rdata", 64'd0, 64'(rd));
        end
    endtask

    task automatic clint_write(input addr_t offset, input data_t wd);
        data_t rd;
        resp_t rs;
        int lat;
        int aw0;
        int w0;
        int tx0;
        aw0 = aw_count;
        w0 = w_count;
        tx0 = ext_txns;
        run_access(1'b1, 1'b1, `CLINT_BASE + offset, wd, 4'hf, rd, rs, lat);
        check_value("clint write resp", 64'(`RESP_SLVERR), 64'(rs));
        check_value("clint write latency", 64'd1, 64'(lat));
        check_value("aw handshakes", 64'(aw0), 64'(aw_count));
        check_value("w handshakes", 64'(w0), 64'(w_count));
        check_value("external transactions", 64'(tx0), 64'(ext_txns));
    endtask

    // both requesters rise in the same idle cycle
    task automatic race_fetch_lsu(input addr_t addr_l, input addr_t addr_f);
        int n;
        int lsu_at;
        int fetch_at;
        @(negedge clock);
        lsu_req = 1'b1;
        lsu_write = 1'b0;
        lsu_addr = addr_l;
        fetch_req = 1'b1;
        fetch_addr = addr_f;
        n = 0;
        lsu_at = 0;
        fetch_at = 0;
        while (lsu_at == 0 || fetch_at == 0) begin
            @(negedge clock);
            n++;
            if (lsu_done) begin
                lsu_at = n;
                lsu_req = 1'b0;
                check_value("lsu_rdata", 64'(model_word(addr_l)), 64'(lsu_rdata));
                check_value("lsu_resp", 64'(`RESP_OKAY), 64'(lsu_resp));
            end
            if (fetch_done) begin
                fetch_at = n;
                fetch_req = 1'b0;
                check_value("fetch_rdata", 64'(model_word(addr_f)), 64'(fetch_rdata));
                check_value("fetch_resp", 64'(`RESP_OKAY), 64'(fetch_resp));
            end
        end
        check_value("lsu_done before fetch_done", 64'd1, 64'(lsu_at < fetch_at));
    endtask

    initial begin
        addr_t a;
        int unsigned kind;
        void'($urandom(SEED));
        reset = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        lsu_req = 1'b0;
        lsu_write = 1'b0;
        lsu_addr = '0;
        lsu_wdata = '0;
        lsu_strb = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("awvalid", 64'd0, 64'(awvalid));
        check_value("wvalid", 64'd0, 64'(wvalid));
        check_value("arvalid", 64'd0, 64'(arvalid));
        check_value("bready", 64'd0, 64'(bready));
        check_value("rready", 64'd0, 64'(rready));
        check_value("fetch_done", 64'd0, 64'(fetch_done));
        check_value("lsu_done", 64'd0, 64'(lsu_done));

        // partial strobes, old word then merged word
        for (int k = 0; k < 4; k++) begin
            a = 32'h8000_0000 + 32'(k * 4);
            ext_read(1'b1, a);
            ext_write(a, $urandom, strb_t'(k + 5));
            ext_read(1'b1, a);
        end
        ext_read(1'b0, 32'h8000_0004);
        clint_read(1'b1, 32'd8);
        clint_read(1'b0, 32'd8);
        clint_read(1'b1, 32'd12);
        clint_write(32'd8, $urandom);
        race_fetch_lsu(32'h8000_0008, 32'h8000_000c);

        for (int i = 0; i < N_RANDOM; i++) begin
            kind = $urandom % 8;
            case (kind)
                0, 1: ext_write(pick_ext(), $urandom, strb_t'($urandom));
                2: ext_read(1'b1, pick_ext());
                3: ext_read(1'b0, pick_ext());
                4: clint_read(($urandom % 2) == 0, 32'd8);
                5: clint_read(1'b1, (($urandom % 2) == 0) ? 32'd12 : 32'd0);
                6: clint_write((($urandom % 2) == 0) ? 32'd8 : 32'd12, $urandom);
                default: race_fetch_lsu(pick_ext(), pick_ext());
            endcase
        end

        @(negedge clock);
        $display("errors: %0d, external transactions: %0d", errors, ext_txns);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: accesses still running after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
bus_pkg.sv
ctrl_pkg.sv
mem_arbiter.sv
clint_timer.sv
axi_lite_bridge_fsm.sv
mem_access_top.sv
tb_mem_access.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_access -f project.f \
    && ./obj_dir/Vtb_mem_access > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
exit 0
